// ==== filelist.f ====
+incdir+.
sha3_pad_pkg.sv
pad_ctrl_if.sv
block_counter.sv
pad_fsm.sv
prefix_gen.sv
funcpad_gen.sv
beat_mux.sv
sha3_pad_top.sv
sha3_pad_checker.sv
tb_sha3_pad.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_sha3_pad
FILELIST  ?= filelist.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_sha3_pad.sv ====
////////////////////
// SHA3 padding unit testbench
// drives hashes through the DUT, models the Keccak engine and
// compares every absorbed block with a reference padded stream
////////////////////

`timescale 1ns/1ps
`include "sha3_pad_defs.svh"

module tb_sha3_pad;
  import sha3_pad_pkg::*;

  localparam int NumTests = 15;
  localparam int CycleLimit = NumTests * 4 * 40 + 6000;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      msg_valid_i;
  logic [`MSG_WIDTH-1:0]     msg_data_i;
  logic [`MSG_STRB_W-1:0]    msg_strb_i;
  logic                      msg_ready_o;
  logic [`NS_BYTES*8-1:0]    ns_data_i;
  logic                      keccak_valid_o;
  logic [`KECCAK_ADDR_W-1:0] keccak_addr_o;
  logic [`MSG_WIDTH-1:0]     keccak_data_o;
  logic                      keccak_ready_i;
  logic                      keccak_run_o;
  logic                      keccak_complete_i;
  sha3_mode_e                mode_i;
  keccak_strength_e          strength_i;
  logic                      start_i;
  logic                      process_i;
  logic                      done_i;
  logic                      absorbed_o;

  integer seed;
  int     errors;
  int     cycles;
  int     blk_idx;
  int     absorbed_count;
  int     cpl_wait;
  bit     bp_on;
  logic [`MSG_WIDTH-1:0] beat_mem [0:31];
  logic [7:0] msg_q[$];
  logic [7:0] exp_q[$];

  sha3_pad_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // block length in words for each strength
  function automatic int rate_words(keccak_strength_e s);
    case (s)
      L128: return 21;
      L224: return 18;
      L256: return 17;
      L384: return 13;
      default: return 9;
    endcase
  endfunction

  // expected padded byte stream, prefix block first for cSHAKE
  function automatic void build_expected(sha3_mode_e m, keccak_strength_e s);
    int rb;
    rb = rate_words(s) * 8;
    exp_q.delete();
    if (m == CShake) begin
      exp_q.push_back(8'h01);
      exp_q.push_back(8'(rb));
      for (int i = 0; i < `NS_BYTES; i++) exp_q.push_back(ns_data_i[i*8 +: 8]);
      while (exp_q.size() % rb != 0) exp_q.push_back(8'h00);
    end
    foreach (msg_q[i]) exp_q.push_back(msg_q[i]);
    exp_q.push_back(m == Sha3 ? 8'h06 : (m == Shake ? 8'h1f : 8'h04));
    while (exp_q.size() % rb != 0) exp_q.push_back(8'h00);
    exp_q[exp_q.size()-1] = exp_q[exp_q.size()-1] | 8'h80;
  endfunction

  ////////////////////
  // engine model
  ////////////////////

  // stores beats by address and checks each block when the engine is run
  always @(posedge clk_i) begin
    logic [`MSG_WIDTH-1:0] want;
    int rw;
    rw = rate_words(strength_i);
    if (keccak_valid_o && keccak_ready_i) beat_mem[keccak_addr_o] = keccak_data_o;
    if (cpl_wait > 0) cpl_wait = cpl_wait - 1;
    if (keccak_run_o) begin
      cpl_wait = 3 + ($unsigned($random(seed)) % 8);
      if ((blk_idx + 1) * rw * 8 > exp_q.size()) begin
        $display("** Error at %0t: unexpected engine run for block %0d", $time, blk_idx);
        errors++;
      end else begin
        for (int w = 0; w < rw; w++) begin
          for (int b = 0; b < 8; b++) want[b*8 +: 8] = exp_q[(blk_idx*rw + w)*8 + b];
          if (beat_mem[w] !== want) begin
            $display("** Error at %0t: block %0d word %0d got %h expected %h",
                     $time, blk_idx, w, beat_mem[w], want);
            errors++;
          end
        end
      end
      // a marker per address, so a word missing from the next block shows up
      for (int w = 0; w < 32; w++) begin
        beat_mem[w] = {8{8'ha0 | 8'(w)}};
      end
      blk_idx++;
    end
    if (absorbed_o) absorbed_count++;
    cycles++;
    if (cycles > CycleLimit) begin
      $display("run stopped: cycle limit of %0d reached before the tests ended", CycleLimit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  always @(negedge clk_i) begin
    keccak_ready_i = bp_on ? (($random(seed) % 4) != 0) : 1'b1;
    keccak_complete_i = (cpl_wait == 1);
  end

  // one hash: start, message words, optional partial word, process, done
  task automatic run_hash(sha3_mode_e m, keccak_strength_e s, int nwords, int tail, bit bp);
    logic [`MSG_WIDTH-1:0] word;
    int nblocks;
    @(negedge clk_i);
    mode_i = m;
    strength_i = s;
    bp_on = bp;
    msg_q.delete();
    for (int i = 0; i < nwords * 8 + tail; i++) msg_q.push_back(8'($random(seed)));
    build_expected(m, s);
    nblocks = exp_q.size() / (rate_words(s) * 8);
    blk_idx = 0;
    absorbed_count = 0;
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    for (int w = 0; w <= nwords; w++) begin
      if (w == nwords && tail == 0) break;
      // bytes past a partial tail are random and must be ignored
      word = {$random(seed), $random(seed)};
      for (int b = 0; b < 8; b++) begin
        if (w * 8 + b < msg_q.size()) word[b*8 +: 8] = msg_q[w*8 + b];
      end
      msg_valid_i = 1'b1;
      msg_data_i = word;
      msg_strb_i = (w == nwords) ? 8'((1 << tail) - 1) : 8'hff;
      @(posedge clk_i);
      while (!msg_ready_o) @(posedge clk_i);
      @(negedge clk_i);
    end
    msg_valid_i = 1'b0;
    process_i = 1'b1;
    @(negedge clk_i);
    process_i = 1'b0;
    while (absorbed_count == 0) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    if (absorbed_count != 1) begin
      $display("** Error at %0t: absorbed pulsed %0d times", $time, absorbed_count);
      errors++;
    end
    if (blk_idx != nblocks) begin
      $display("** Error at %0t: %0d runs, expected %0d", $time, blk_idx, nblocks);
      errors++;
    end
    done_i = 1'b1;
    @(negedge clk_i);
    done_i = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  task automatic check_idle_outputs();
    if (keccak_valid_o || msg_ready_o || keccak_run_o || absorbed_o) begin
      $display("** Error at %0t: outputs not low around reset", $time);
      errors++;
    end
  endtask

  initial begin
    seed = 3;
    errors = 0;
    cycles = 0;
    blk_idx = 0;
    absorbed_count = 0;
    cpl_wait = 0;
    bp_on = 1'b0;
    rst_ni = 1'b0;
    msg_valid_i = 1'b0;
    msg_data_i = '0;
    msg_strb_i = '0;
    keccak_ready_i = 1'b0;
    keccak_complete_i = 1'b0;
    start_i = 1'b0;
    process_i = 1'b0;
    done_i = 1'b0;
    mode_i = Sha3;
    strength_i = L256;
    ns_data_i = {$random(seed), $random(seed), $random(seed), $random(seed)};
    repeat (16) begin
      @(posedge clk_i);
      check_idle_outputs();
    end
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_idle_outputs();

    run_hash(Sha3, L256, 40, 0, 1'b0);
    run_hash(Sha3, L256, 34, 0, 1'b0);
    for (int t = 0; t < 8; t++) run_hash(Shake, L128, 3 + t * 3, t, 1'b0);
    // pad word on the last word of the block, then zero fill after it
    run_hash(Sha3, L512, 8, 3, 1'b0);
    run_hash(Sha3, L512, 12, 6, 1'b0);
    run_hash(CShake, L256, 20, 5, 1'b0);
    run_hash(CShake, L256, 16, 0, 1'b1);
    run_hash(Sha3, L384, 25, 7, 1'b1);

    $display("checks done: %0d errors", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sha3_pad_checker.sv ====
////////////////////
// SHA3 padding unit port assertions
// pulse widths, back-pressure stability and address range
////////////////////

`timescale 1ns/1ps
`include "sha3_pad_defs.svh"

module sha3_pad_checker (
  input logic                           clk_i,
  input logic                           rst_ni,
  input sha3_pad_pkg::keccak_strength_e strength_i,
  input logic                           keccak_valid_o,
  input logic                           keccak_ready_i,
  input logic [`KECCAK_ADDR_W-1:0]      keccak_addr_o,
  input logic [`MSG_WIDTH-1:0]          keccak_data_o,
  input logic                           keccak_run_o,
  input logic                           absorbed_o
);
  import sha3_pad_pkg::*;

  // block length in words of each strength, all of them inside the 25-word state
  function automatic int unsigned block_words(keccak_strength_e s);
    case (s)
      L128:    return 21;
      L224:    return 18;
      L256:    return 17;
      L384:    return 13;
      default: return 9;
    endcase
  endfunction

  // the engine is started with a single-cycle pulse
  run_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    keccak_run_o |=> !keccak_run_o)
    else $error("keccak_run_o longer than one cycle");

  absorbed_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    absorbed_o |=> !absorbed_o)
    else $error("absorbed_o longer than one cycle");

  // a stalled beat keeps valid, address and data
  stall_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    keccak_valid_o && !keccak_ready_i |=>
      keccak_valid_o && $stable(keccak_data_o) && $stable(keccak_addr_o))
    else $error("beat changed under back-pressure");

  // a beat lands inside the rate area of the selected strength
  addr_range_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    keccak_valid_o |-> keccak_addr_o < block_words(strength_i))
    else $error("beat address out of range");

endmodule

bind sha3_pad_top sha3_pad_checker u_checker (.*);

// ==== sha3_pad_top.sv ====
////////////////////
// SHA3 padding unit
// feeds message, cSHAKE prefix and padding beats into the Keccak rate area
////////////////////

`timescale 1ns/1ps
`include "sha3_pad_defs.svh"

module sha3_pad_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  // message source
  input  logic                           msg_valid_i,
  input  logic [`MSG_WIDTH-1:0]          msg_data_i,
  input  logic [`MSG_STRB_W-1:0]         msg_strb_i,
  output logic                           msg_ready_o,

  // encoded N and S, used by cSHAKE only
  input  logic [`NS_BYTES*8-1:0]         ns_data_i,

  // Keccak rate area write port
  output logic                           keccak_valid_o,
  output logic [`KECCAK_ADDR_W-1:0]      keccak_addr_o,
  output logic [`MSG_WIDTH-1:0]          keccak_data_o,
  input  logic                           keccak_ready_i,

  // engine run and its completion
  output logic                           keccak_run_o,
  input  logic                           keccak_complete_i,

  // configuration, held stable for a whole hash
  input  sha3_pad_pkg::sha3_mode_e       mode_i,
  input  sha3_pad_pkg::keccak_strength_e strength_i,

  // hash control pulses
  input  logic                           start_i,
  input  logic                           process_i,
  input  logic                           done_i,
  output logic                           absorbed_o
);

  logic [`MSG_WIDTH-1:0] prefix_beat;
  logic [`MSG_WIDTH-1:0] funcpad_beat;
  logic [`MSG_WIDTH-1:0] zero_end_beat;
  logic                  keccak_ack;

  pad_ctrl_if ctrl ();

  // a beat is written on valid and ready together
  assign keccak_ack = keccak_valid_o & keccak_ready_i;

  pad_fsm u_pad_fsm (
    .clk_i,
    .rst_ni,
    .mode_i,
    .msg_valid_i,
    .msg_strb_i,
    .keccak_ack_i (keccak_ack),
    .keccak_complete_i,
    .start_i,
    .process_i,
    .done_i,
    .ctrl         (ctrl),
    .keccak_run_o,
    .absorbed_o
  );

  block_counter u_block_counter (
    .clk_i,
    .rst_ni,
    .strength_i,
    .keccak_valid_i (keccak_valid_o),
    .keccak_ready_i,
    .ctrl           (ctrl),
    .keccak_addr_o
  );

  // the prefix is sliced by the raw beat count
  prefix_gen u_prefix_gen (
    .strength_i,
    .ns_data_i,
    .beat_addr_i   (ctrl.beat_count),
    .prefix_beat_o (prefix_beat)
  );

  funcpad_gen u_funcpad_gen (
    .clk_i,
    .rst_ni,
    .mode_i,
    .msg_data_i,
    .msg_strb_i,
    .ctrl            (ctrl),
    .funcpad_beat_o  (funcpad_beat),
    .zero_end_beat_o (zero_end_beat)
  );

  beat_mux u_beat_mux (
    .ctrl            (ctrl),
    .msg_valid_i,
    .msg_data_i,
    .keccak_ready_i,
    .prefix_beat_i   (prefix_beat),
    .funcpad_beat_i  (funcpad_beat),
    .zero_end_beat_i (zero_end_beat),
    .keccak_valid_o,
    .keccak_data_o,
    .msg_ready_o
  );

endmodule

// ==== beat_mux.sv ====
////////////////////
// output beat select
// picks the Keccak write data and derives valid and message ready
////////////////////

`timescale 1ns/1ps
`include "sha3_pad_defs.svh"

module beat_mux (
  pad_ctrl_if.datapath          ctrl,
  input  logic                  msg_valid_i,
  input  logic [`MSG_WIDTH-1:0] msg_data_i,
  input  logic                  keccak_ready_i,
  input  logic [`MSG_WIDTH-1:0] prefix_beat_i,
  input  logic [`MSG_WIDTH-1:0] funcpad_beat_i,
  input  logic [`MSG_WIDTH-1:0] zero_end_beat_i,
  output logic                  keccak_valid_o,
  output logic [`MSG_WIDTH-1:0] keccak_data_o,
  output logic                  msg_ready_o
);
  import sha3_pad_pkg::*;

  always_comb begin
    keccak_data_o  = '0;
    keccak_valid_o = 1'b0;
    msg_ready_o    = 1'b0;
    unique case (ctrl.beat_sel)
      SelMsg: begin
        // message words pass straight through unless held or being buffered
        keccak_data_o  = msg_data_i;
        keccak_valid_o = msg_valid_i & ~ctrl.hold_msg & ~ctrl.buf_en;
        // a buffered partial word is taken without waiting for the engine
        msg_ready_o    = ctrl.buf_en | (keccak_ready_i & ~ctrl.hold_msg);
      end
      SelPrefix: begin
        keccak_data_o  = prefix_beat_i;
        keccak_valid_o = ctrl.fsm_valid;
      end
      SelFuncPad: begin
        keccak_data_o  = funcpad_beat_i;
        keccak_valid_o = ctrl.fsm_valid;
      end
      SelZeroEnd: begin
        keccak_data_o  = zero_end_beat_i;
        keccak_valid_o = ctrl.fsm_valid;
      end
      default: begin
        keccak_data_o = '0;
      end
    endcase
  end

endmodule

// ==== funcpad_gen.sv ====
////////////////////
// function pad builder
// buffers the partial last word and merges it with the mode suffix,
// also forms the zero-fill word with the closing pad10*1 bit
////////////////////

`timescale 1ns/1ps
`include "sha3_pad_defs.svh"

module funcpad_gen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  sha3_pad_pkg::sha3_mode_e mode_i,
  input  logic [`MSG_WIDTH-1:0]    msg_data_i,
  input  logic [`MSG_STRB_W-1:0]   msg_strb_i,
  pad_ctrl_if.datapath             ctrl,
  output logic [`MSG_WIDTH-1:0]    funcpad_beat_o,
  output logic [`MSG_WIDTH-1:0]    zero_end_beat_o
);
  import sha3_pad_pkg::*;

  // a partial word has at most seven valid bytes, so the top byte is not kept
  logic [`MSG_WIDTH-9:0]  buf_data_q;
  logic [`MSG_STRB_W-2:0] buf_strb_q;
  logic [7:0]             suffix;
  logic [`MSG_WIDTH-1:0]  buf_ext;
  logic [`MSG_STRB_W-1:0] strb_ext;
  logic [`MSG_STRB_W-1:0] strb_prev;

  always_ff @(posedge clk_i) begin
    if (ctrl.buf_en) begin
      buf_data_q <= msg_data_i[`MSG_WIDTH-9:0];
    end
  end

  // the strobe alone decides which buffered bytes are used
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_strb_q <= '0;
    end else if (ctrl.buf_en) begin
      buf_strb_q <= msg_strb_i[`MSG_STRB_W-2:0];
    end else if (ctrl.buf_clr) begin
      buf_strb_q <= '0;
    end
  end

  // domain suffix with the first pad10*1 bit already appended
  always_comb begin
    unique case (mode_i)
      Sha3:    suffix = 8'h06;
      Shake:   suffix = 8'h1f;
      CShake:  suffix = 8'h04;
      default: suffix = 8'h01;
    endcase
  end

  assign buf_ext   = {8'h00, buf_data_q};
  assign strb_ext  = {1'b0, buf_strb_q};
  // strobes are contiguous, the suffix lands on the first unset byte
  assign strb_prev = {buf_strb_q, 1'b1};

  always_comb begin
    funcpad_beat_o = '0;
    for (int b = 0; b < `MSG_STRB_W; b++) begin
      if (strb_ext[b]) begin
        funcpad_beat_o[b*8 +: 8] = buf_ext[b*8 +: 8];
      end else if (strb_prev[b]) begin
        funcpad_beat_o[b*8 +: 8] = suffix;
      end
    end
    // closing bit of pad10*1 when the pad word is also the block's last word
    funcpad_beat_o[`MSG_WIDTH-1] = funcpad_beat_o[`MSG_WIDTH-1] | ctrl.end_of_block;
  end

  assign zero_end_beat_o = {ctrl.end_of_block, {(`MSG_WIDTH-1){1'b0}}};

endmodule

// ==== prefix_gen.sv ====
////////////////////
// cSHAKE prefix builder
// bytepad header plus N/S string, sliced into 64-bit beats by address
////////////////////

`timescale 1ns/1ps
`include "sha3_pad_defs.svh"

module prefix_gen (
  input  sha3_pad_pkg::keccak_strength_e strength_i,
  input  logic [`NS_BYTES*8-1:0]         ns_data_i,
  input  logic [`KECCAK_ADDR_W-1:0]      beat_addr_i,
  output logic [`MSG_WIDTH-1:0]          prefix_beat_o
);
  import sha3_pad_pkg::*;

  // number of beats that hold non-zero prefix bytes
  localparam int PrefixWords = (`PREFIX_BYTES * 8 + `MSG_WIDTH - 1) / `MSG_WIDTH;
  localparam int PrefixW     = PrefixWords * `MSG_WIDTH;

  logic [7:0]         rate_bytes;
  logic [PrefixW-1:0] prefix;

  // left_encode of the rate in bytes, the length byte itself is fixed at 0x01
  always_comb begin
    unique case (strength_i)
      L128:    rate_bytes = 8'(8 * `RATE_WORDS_L128);
      L224:    rate_bytes = 8'(8 * `RATE_WORDS_L224);
      L256:    rate_bytes = 8'(8 * `RATE_WORDS_L256);
      L384:    rate_bytes = 8'(8 * `RATE_WORDS_L384);
      L512:    rate_bytes = 8'(8 * `RATE_WORDS_L512);
      default: rate_bytes = 8'h00;
    endcase
  end

  // byte 0 sits in the low byte of beat 0, zeros follow past the N/S string
  assign prefix = PrefixW'({ns_data_i, rate_bytes, 8'h01});

  // beats beyond the prefix belong to the zero fill of the block
  always_comb begin
    prefix_beat_o = '0;
    for (int w = 0; w < PrefixWords; w++) begin
      if (beat_addr_i == `KECCAK_ADDR_W'(w)) begin
        prefix_beat_o = prefix[w*`MSG_WIDTH +: `MSG_WIDTH];
      end
    end
  end

endmodule

// ==== pad_fsm.sv ====
////////////////////
// SHA3 padding state machine
// sequences prefix, message, function pad and zero fill per hash,
// and runs the Keccak engine once per full block
////////////////////

`timescale 1ns/1ps
`include "sha3_pad_defs.svh"

module pad_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  sha3_pad_pkg::sha3_mode_e mode_i,
  input  logic                     msg_valid_i,
  input  logic [`MSG_STRB_W-1:0]   msg_strb_i,
  input  logic                     keccak_ack_i,
  input  logic                     keccak_complete_i,
  input  logic                     start_i,
  input  logic                     process_i,
  input  logic                     done_i,
  pad_ctrl_if.fsm                  ctrl,
  output logic                     keccak_run_o,
  output logic                     absorbed_o
);
  import sha3_pad_pkg::*;

  pad_state_e state_q, state_d;
  beat_sel_e  sel;
  logic       fsm_valid;
  logic       hold_msg;
  logic       buf_en;
  logic       buf_clr;
  logic       cnt_clr;
  logic       absorbed_d;
  logic       process_q;
  logic       msg_partial;

  // a word without all strobes set is the last, partial word of the message
  assign msg_partial = ~&msg_strb_i;

  // process may arrive while the prefix block is still in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      process_q <= 1'b0;
    end else if (process_i) begin
      process_q <= 1'b1;
    end else if (done_i) begin
      process_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      absorbed_o <= 1'b0;
    end else begin
      state_q    <= state_d;
      absorbed_o <= absorbed_d;
    end
  end

  ////////////////////
  // next state and command decode
  ////////////////////

  always_comb begin
    state_d      = state_q;
    sel          = SelNone;
    fsm_valid    = 1'b0;
    hold_msg     = 1'b0;
    buf_en       = 1'b0;
    buf_clr      = 1'b0;
    cnt_clr      = 1'b0;
    keccak_run_o = 1'b0;
    absorbed_d   = 1'b0;

    unique case (state_q)
      Idle: begin
        // only cSHAKE puts a bytepad prefix block in front of the message
        if (start_i) begin
          state_d = (mode_i == CShake) ? Prefix : Message;
        end
      end

      Prefix: begin
        sel = SelPrefix;
        if (ctrl.block_sent) begin
          keccak_run_o = 1'b1;
          cnt_clr      = 1'b1;
          state_d      = PrefixWait;
        end else begin
          fsm_valid = 1'b1;
        end
      end

      PrefixWait: begin
        sel = SelPrefix;
        if (keccak_complete_i) begin
          state_d = Message;
        end
      end

      Message: begin
        sel = SelMsg;
        if (ctrl.block_sent) begin
          // a full block is run before a partial word or the process request
          keccak_run_o = 1'b1;
          cnt_clr      = 1'b1;
          hold_msg     = 1'b1;
          state_d      = MessageWait;
        end else if (msg_valid_i && msg_partial) begin
          // a partial word goes into the buffer and no beat is sent for it
          buf_en = 1'b1;
        end else if (process_q || process_i) begin
          hold_msg = 1'b1;
          state_d  = Pad;
        end
      end

      MessageWait: begin
        hold_msg = 1'b1;
        if (keccak_complete_i) begin
          state_d = Message;
        end
      end

      Pad: begin
        sel       = SelFuncPad;
        fsm_valid = 1'b1;
        if (keccak_ack_i) begin
          buf_clr = 1'b1;
          // pad word on the last word carries bit 63 as well, block is done
          if (ctrl.end_of_block) begin
            cnt_clr = 1'b1;
            state_d = PadRun;
          end else begin
            state_d = Pad01;
          end
        end
      end

      PadRun: begin
        keccak_run_o = 1'b1;
        cnt_clr      = 1'b1;
        state_d      = Flush;
      end

      Pad01: begin
        // zero fill up to the last word, which ends with the final pad bit
        sel = SelZeroEnd;
        if (ctrl.block_sent) begin
          keccak_run_o = 1'b1;
          cnt_clr      = 1'b1;
          state_d      = Flush;
        end else begin
          fsm_valid = 1'b1;
        end
      end

      Flush: begin
        cnt_clr = 1'b1;
        buf_clr = 1'b1;
        if (keccak_complete_i) begin
          absorbed_d = 1'b1;
          state_d    = Idle;
        end
      end

      default: begin
        state_d = Idle;
      end
    endcase
  end

  assign ctrl.beat_sel  = sel;
  assign ctrl.fsm_valid = fsm_valid;
  assign ctrl.hold_msg  = hold_msg;
  assign ctrl.buf_en    = buf_en;
  assign ctrl.buf_clr   = buf_clr;
  assign ctrl.cnt_clr   = cnt_clr;

endmodule

// ==== block_counter.sv ====
////////////////////
// per-block beat counter
// counts transferred beats, flags block end and drives the beat address
////////////////////

`timescale 1ns/1ps
`include "sha3_pad_defs.svh"

module block_counter (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  sha3_pad_pkg::keccak_strength_e strength_i,
  input  logic                           keccak_valid_i,
  input  logic                           keccak_ready_i,
  pad_ctrl_if.counter                    ctrl,
  output logic [`KECCAK_ADDR_W-1:0]      keccak_addr_o
);
  import sha3_pad_pkg::*;

  logic [`KECCAK_COUNT_W-1:0] block_limit;
  logic [`KECCAK_COUNT_W-1:0] count_q;

  // words per block for the selected strength
  always_comb begin
    unique case (strength_i)
      L128:    block_limit = `KECCAK_COUNT_W'(`RATE_WORDS_L128);
      L224:    block_limit = `KECCAK_COUNT_W'(`RATE_WORDS_L224);
      L256:    block_limit = `KECCAK_COUNT_W'(`RATE_WORDS_L256);
      L384:    block_limit = `KECCAK_COUNT_W'(`RATE_WORDS_L384);
      L512:    block_limit = `KECCAK_COUNT_W'(`RATE_WORDS_L512);
      default: block_limit = '0;
    endcase
  end

  // a clear from the FSM wins over a beat transferred in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (ctrl.cnt_clr) begin
      count_q <= '0;
    end else if (keccak_valid_i && keccak_ready_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign ctrl.beat_count = count_q;

  // one word left in the block, so this beat closes it
  assign ctrl.end_of_block = ((count_q + 1'b1) == block_limit);
  assign ctrl.block_sent   = (count_q == block_limit);

  // the address never runs past the rate area, it wraps to zero at the limit
  assign keccak_addr_o = (count_q < block_limit) ? count_q : '0;

endmodule

// ==== pad_ctrl_if.sv ====
////////////////////
// padding control bundle
// FSM commands to the datapath and block position back from the counter
////////////////////

`timescale 1ns/1ps
`include "sha3_pad_defs.svh"

interface pad_ctrl_if;
  import sha3_pad_pkg::*;

  // commands issued by the FSM
  beat_sel_e beat_sel;
  logic      fsm_valid;
  logic      hold_msg;
  logic      buf_en;
  logic      buf_clr;
  logic      cnt_clr;

  // position of the current beat inside the block
  logic [`KECCAK_COUNT_W-1:0] beat_count;
  // the current beat is the last word of the block
  logic                       end_of_block;
  // the whole block has been written
  logic                       block_sent;

  modport fsm (
    output beat_sel, fsm_valid, hold_msg, buf_en, buf_clr, cnt_clr,
    input  beat_count, end_of_block, block_sent
  );

  // the pad word builder also needs to know whether it lands on the last word
  modport datapath (
    input beat_sel, fsm_valid, hold_msg, buf_en, buf_clr, end_of_block
  );

  modport counter (
    input  cnt_clr,
    output beat_count, end_of_block, block_sent
  );

endinterface

// ==== sha3_pad_pkg.sv ====
////////////////////
// SHA3 padding unit types
// hash mode, strength, output beat select and FSM state encodings
////////////////////

package sha3_pad_pkg;

  // hash function, selects the suffix and whether a prefix block is sent
  typedef enum logic [1:0] {
    Sha3   = 2'd0,
    Shake  = 2'd1,
    CShake = 2'd2
  } sha3_mode_e;

  // security strength, which sets the block length
  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } keccak_strength_e;

  // source of the beat offered to the Keccak write port
  typedef enum logic [2:0] {
    SelNone    = 3'd0,
    SelMsg     = 3'd1,
    SelPrefix  = 3'd2,
    SelFuncPad = 3'd3,
    SelZeroEnd = 3'd4
  } beat_sel_e;

  // padding FSM states
  typedef enum logic [3:0] {
    Idle        = 4'd0,
    Prefix      = 4'd1,
    PrefixWait  = 4'd2,
    Message     = 4'd3,
    MessageWait = 4'd4,
    Pad         = 4'd5,
    PadRun      = 4'd6,
    Pad01       = 4'd7,
    Flush       = 4'd8
  } pad_state_e;

endpackage

// ==== sha3_pad_defs.svh ====
////////////////////
// SHA3 padding unit shared widths and constants
// message beat geometry, N/S prefix length and the Keccak rate table
////////////////////

`ifndef SHA3_PAD_DEFS_SVH
`define SHA3_PAD_DEFS_SVH

// one message word and one Keccak beat share the same width
`define MSG_WIDTH 64

// one strobe bit per message byte
`define MSG_STRB_W 8

// encoded N and S string length in bytes, prepared by the host
`define NS_BYTES 16

// two leading bytes of bytepad() in front of the N/S string
`define PREFIX_BYTES (`NS_BYTES + 2)

// beat address and per-block counter widths
`define KECCAK_ADDR_W 5
`define KECCAK_COUNT_W 5

// block length in 64-bit words for each strength
`define RATE_WORDS_L128 21
`define RATE_WORDS_L224 18
`define RATE_WORDS_L256 17
`define RATE_WORDS_L384 13
`define RATE_WORDS_L512 9

`endif
